/* design/floo_meta_pkg.sv */
// Meta buffer subsystem package
// Sizes, opcodes and buffered metadata types shared by all blocks
`default_nettype none

package floo_meta_pkg;

  // Upstream and downstream transaction ID widths
  localparam int unsigned ID_W = 4;
  localparam int unsigned DN_ID_W = 3;

  // Atomic slots use downstream IDs 0 .. NUM_ATOP_SLOTS-1
  localparam int unsigned NUM_ATOP_SLOTS = 2;
  localparam int unsigned SLOT_W = $clog2(NUM_ATOP_SLOTS);

  // Every non-atomic request shares this downstream ID
  localparam logic [DN_ID_W-1:0] NOATOP_DN_ID = '1;

  // Non-atomic metadata FIFO
  localparam int unsigned META_DEPTH = 4;
  localparam int unsigned PTR_W = $clog2(META_DEPTH);
  localparam int unsigned CNT_W = $clog2(META_DEPTH + 1);

  // Memory endpoint geometry
  localparam int unsigned ADDR_W = 4;
  localparam int unsigned NUM_WORDS = 2 ** ADDR_W;
  localparam int unsigned DATA_W = 32;

  // Source node tag carried back with the response
  localparam int unsigned META_W = 6;

  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_ATOP_ADD,
    OP_ATOP_SWAP
  } mem_op_e;

  // What must survive until the response returns
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [META_W-1:0] meta;
  } meta_buf_t;

  typedef enum logic [1:0] {
    IDLE,
    RMW,
    RESP
  } tgt_state_e;

endpackage

`default_nettype wire

/* design/floo_meta_if.sv */
// Downstream request and response channels
// Valid/ready handshake between the meta buffer and the memory endpoint
`timescale 1ns/100ps
`default_nettype none

interface meta_req_if import floo_meta_pkg::*; ();
  logic               valid;
  logic               ready;
  mem_op_e            op;
  logic [DN_ID_W-1:0] id;
  logic [ADDR_W-1:0]  addr;
  logic [DATA_W-1:0]  wdata;

  modport initiator (
    output valid, op, id, addr, wdata,
    input  ready
  );
  modport target (
    input  valid, op, id, addr, wdata,
    output ready
  );
endinterface

interface meta_rsp_if import floo_meta_pkg::*; ();
  logic               valid;
  logic               ready;
  logic [DN_ID_W-1:0] id;
  logic [DATA_W-1:0]  rdata;

  modport initiator (
    output valid, id, rdata,
    input  ready
  );
  modport target (
    input  valid, id, rdata,
    output ready
  );
endinterface

`default_nettype wire

/* design/floo_meta_fifo.sv */
// In-order metadata FIFO for non-atomic transactions
// Head entry is always visible on data_o
`timescale 1ns/100ps
`default_nettype none

module floo_meta_fifo import floo_meta_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      push_i,
  input  meta_buf_t data_i,
  output logic      full_o,
  input  logic      pop_i,
  output meta_buf_t data_o
);

  meta_buf_t        mem_q [META_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  assign full_o = (count_q == CNT_W'(META_DEPTH));
  assign data_o = mem_q[rd_ptr_q];

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the fill level
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* design/floo_atop_slots.sv */
// Atomic ID slot table
// Hands out a free slot index as downstream ID and keeps the
// original ID and tag of each outstanding atomic
`timescale 1ns/100ps
`default_nettype none

module floo_atop_slots import floo_meta_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              alloc_i,
  input  meta_buf_t         alloc_data_i,
  output logic [SLOT_W-1:0] alloc_id_o,
  output logic              avail_o,
  input  logic              free_i,
  input  logic [SLOT_W-1:0] free_id_i,
  output meta_buf_t         slot_data_o
);

  logic [NUM_ATOP_SLOTS-1:0] busy_q;
  logic [NUM_ATOP_SLOTS-1:0] busy_d;
  meta_buf_t                 slot_q [NUM_ATOP_SLOTS];
  logic [SLOT_W-1:0]         alloc_id_q;
  logic [SLOT_W-1:0]         lowest_free;

  always_comb begin
    busy_d = busy_q;
    if (alloc_i) begin
      busy_d[alloc_id_q] = 1'b1;
    end
    if (free_i) begin
      busy_d[free_id_i] = 1'b0;
    end
  end

  // Leading-zero search over the free mask, lowest index wins
  always_comb begin
    lowest_free = '0;
    for (int i = NUM_ATOP_SLOTS - 1; i >= 0; i--) begin
      if (!busy_d[i]) begin
        lowest_free = SLOT_W'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q     <= '0;
      alloc_id_q <= '0;
    end else begin
      busy_q <= busy_d;
      // Move only once the offered slot is taken, so a waiting atomic keeps its ID
      if (busy_d[alloc_id_q]) begin
        alloc_id_q <= lowest_free;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      slot_q[alloc_id_q] <= alloc_data_i;
    end
  end

  assign alloc_id_o  = alloc_id_q;
  assign avail_o     = !busy_q[alloc_id_q];
  assign slot_data_o = slot_q[free_id_i];

endmodule

`default_nettype wire

/* design/floo_meta_buffer.sv */
// Meta buffer
// Replaces the upstream ID with a downstream ID, keeps ID and tag
// until the response comes back and restores them on the way out
`timescale 1ns/100ps
`default_nettype none

module floo_meta_buffer import floo_meta_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_i,
  // Upstream request
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  mem_op_e             req_op_i,
  input  logic [ID_W-1:0]     req_id_i,
  input  logic [ADDR_W-1:0]   req_addr_i,
  input  logic [DATA_W-1:0]   req_wdata_i,
  input  logic [META_W-1:0]   req_meta_i,
  // Upstream response
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output logic [ID_W-1:0]     rsp_id_o,
  output logic [DATA_W-1:0]   rsp_data_o,
  output logic [META_W-1:0]   rsp_meta_o,
  // Downstream channels
  meta_req_if.initiator       dn_req,
  meta_rsp_if.target          dn_rsp
);

  logic              is_atop;
  logic              buf_ok;
  logic              req_fire;
  logic              rsp_fire;
  logic              is_atop_rsp;
  logic              fifo_full;
  logic              fifo_push;
  logic              fifo_pop;
  logic              slot_avail;
  logic              slot_alloc;
  logic              slot_free;
  logic [SLOT_W-1:0] alloc_id;
  meta_buf_t         req_buf;
  meta_buf_t         fifo_head;
  meta_buf_t         slot_head;
  meta_buf_t         rsp_buf;

  assign req_buf = '{id: req_id_i, meta: req_meta_i};

  // Request side
  assign is_atop = (req_op_i == OP_ATOP_ADD) || (req_op_i == OP_ATOP_SWAP);

  // Room to park the metadata of this request
  assign buf_ok = is_atop ? slot_avail : !fifo_full;

  assign dn_req.valid = req_valid_i && buf_ok;
  assign dn_req.op    = req_op_i;
  assign dn_req.id    = is_atop ? DN_ID_W'(alloc_id) : NOATOP_DN_ID;
  assign dn_req.addr  = req_addr_i;
  assign dn_req.wdata = req_wdata_i;
  assign req_ready_o  = dn_req.ready && buf_ok;

  assign req_fire   = dn_req.valid && dn_req.ready;
  assign fifo_push  = req_fire && !is_atop;
  assign slot_alloc = req_fire && is_atop;

  // Response side, low IDs belong to atomic slots
  assign is_atop_rsp = (dn_rsp.id < DN_ID_W'(NUM_ATOP_SLOTS));
  assign rsp_buf     = is_atop_rsp ? slot_head : fifo_head;

  assign rsp_valid_o  = dn_rsp.valid;
  assign dn_rsp.ready = rsp_ready_i;
  assign rsp_id_o     = rsp_buf.id;
  assign rsp_meta_o   = rsp_buf.meta;
  assign rsp_data_o   = dn_rsp.rdata;

  assign rsp_fire  = dn_rsp.valid && rsp_ready_i;
  assign fifo_pop  = rsp_fire && !is_atop_rsp;
  assign slot_free = rsp_fire && is_atop_rsp;

  floo_meta_fifo u_meta_fifo (
    .clk_i  ( clk_i     ),
    .rst_i  ( rst_i     ),
    .push_i ( fifo_push ),
    .data_i ( req_buf   ),
    .full_o ( fifo_full ),
    .pop_i  ( fifo_pop  ),
    .data_o ( fifo_head )
  );

  floo_atop_slots u_atop_slots (
    .clk_i        ( clk_i                   ),
    .rst_i        ( rst_i                   ),
    .alloc_i      ( slot_alloc              ),
    .alloc_data_i ( req_buf                 ),
    .alloc_id_o   ( alloc_id                ),
    .avail_o      ( slot_avail              ),
    .free_i       ( slot_free               ),
    .free_id_i    ( dn_rsp.id[SLOT_W-1:0]   ),
    .slot_data_o  ( slot_head               )
  );

endmodule

`default_nettype wire

/* design/floo_mem_target.sv */
// Word memory endpoint
// Executes read, write, atomic add and atomic swap, one response per request
`timescale 1ns/100ps
`default_nettype none

module floo_mem_target import floo_meta_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_i,
  meta_req_if.target    req,
  meta_rsp_if.initiator rsp
);

  tgt_state_e         state_q;
  tgt_state_e         state_d;
  logic [DATA_W-1:0]  mem_q [NUM_WORDS];
  mem_op_e            op_q;
  logic [DN_ID_W-1:0] id_q;
  logic [ADDR_W-1:0]  addr_q;
  logic [DATA_W-1:0]  wdata_q;
  logic [DATA_W-1:0]  rdata_q;
  logic               req_fire;
  logic               mem_we;
  logic [ADDR_W-1:0]  mem_waddr;
  logic [DATA_W-1:0]  mem_wdata;

  // Only take a request while the response register is empty
  assign req.ready = (state_q == IDLE);
  assign req_fire  = req.valid && req.ready;

  assign rsp.valid = (state_q == RESP);
  assign rsp.id    = id_q;
  assign rsp.rdata = rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_fire) begin
          state_d = (req.op == OP_ATOP_ADD || req.op == OP_ATOP_SWAP) ? RMW : RESP;
        end
      end
      RMW:  state_d = RESP;
      RESP: begin
        if (rsp.ready) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Single write port, plain writes in IDLE and atomic updates in RMW
  always_comb begin
    mem_we    = 1'b0;
    mem_waddr = addr_q;
    mem_wdata = wdata_q;
    if (req_fire && req.op == OP_WRITE) begin
      mem_we    = 1'b1;
      mem_waddr = req.addr;
      mem_wdata = req.wdata;
    end else if (state_q == RMW) begin
      mem_we    = 1'b1;
      mem_wdata = (op_q == OP_ATOP_ADD) ? mem_q[addr_q] + wdata_q : wdata_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      for (int i = 0; i < NUM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      state_q <= state_d;
      if (mem_we) begin
        mem_q[mem_waddr] <= mem_wdata;
      end
    end
  end

  // Request payload and response data
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      op_q    <= req.op;
      id_q    <= req.id;
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
      // Writes answer with zero, atomics fill in the old word in RMW
      rdata_q <= (req.op == OP_READ) ? mem_q[req.addr] : '0;
    end else if (state_q == RMW) begin
      rdata_q <= mem_q[addr_q];
    end
  end

endmodule

`default_nettype wire

/* design/floo_meta_top.sv */
// Meta buffer subsystem top
// Meta buffer in front of a word memory endpoint, closed request/response loop
`timescale 1ns/100ps
`default_nettype none

module floo_meta_top import floo_meta_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  // Request from the network
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  mem_op_e           req_op_i,
  input  logic [ID_W-1:0]   req_id_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  input  logic [META_W-1:0] req_meta_i,
  // Response back to the source node
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output logic [ID_W-1:0]   rsp_id_o,
  output logic [DATA_W-1:0] rsp_data_o,
  output logic [META_W-1:0] rsp_meta_o
);

  meta_req_if dn_req ();
  meta_rsp_if dn_rsp ();

  floo_meta_buffer u_meta_buffer (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_op_i    ( req_op_i    ),
    .req_id_i    ( req_id_i    ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .req_meta_i  ( req_meta_i  ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_id_o    ( rsp_id_o    ),
    .rsp_data_o  ( rsp_data_o  ),
    .rsp_meta_o  ( rsp_meta_o  ),
    .dn_req      ( dn_req      ),
    .dn_rsp      ( dn_rsp      )
  );

  floo_mem_target u_mem_target (
    .clk_i ( clk_i  ),
    .rst_i ( rst_i  ),
    .req   ( dn_req ),
    .rsp   ( dn_rsp )
  );

endmodule

`default_nettype wire

/* verif/floo_meta_checker.sv */
// Meta buffer subsystem checker
// Concurrent assertions on reset, response hold and request stalls
`timescale 1ns/100ps
`default_nettype none

module floo_meta_checker import floo_meta_pkg::*; (
  input logic              clk_i,
  input logic              rst_i,
  input logic              req_ready_i,
  input logic              rsp_valid_i,
  input logic              rsp_ready_i,
  input logic [ID_W-1:0]   rsp_id_i,
  input logic [DATA_W-1:0] rsp_data_i,
  input logic [META_W-1:0] rsp_meta_i,
  input logic              fifo_full_i,
  input logic              slots_full_i,
  input logic              tgt_ready_i
);

  rsp_idle_after_reset: assert property (@(posedge clk_i) rst_i |=> !rsp_valid_i)
    else $error("rsp_valid_o high in the cycle after reset");

  // A stalled response keeps valid and payload
  rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_id_i)
      && $stable(rsp_data_i) && $stable(rsp_meta_i))
    else $error("response changed or dropped while stalled");

  // A slot stall needs every slot taken, not just the offered one
  req_stall_cause: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(req_ready_i) |-> fifo_full_i || slots_full_i || !tgt_ready_i)
    else $error("req_ready_o fell without a full FIFO, busy slots or busy target");

endmodule

bind floo_meta_top floo_meta_checker u_checker (
  .clk_i        ( clk_i                               ),
  .rst_i        ( rst_i                               ),
  .req_ready_i  ( req_ready_o                         ),
  .rsp_valid_i  ( rsp_valid_o                         ),
  .rsp_ready_i  ( rsp_ready_i                         ),
  .rsp_id_i     ( rsp_id_o                            ),
  .rsp_data_i   ( rsp_data_o                          ),
  .rsp_meta_i   ( rsp_meta_o                          ),
  .fifo_full_i  ( u_meta_buffer.fifo_full             ),
  .slots_full_i ( &u_meta_buffer.u_atop_slots.busy_q  ),
  .tgt_ready_i  ( dn_req.ready                        )
);

`default_nettype wire

/* verif/floo_meta_tb.sv */
// Meta buffer subsystem testbench
// Replays request patterns from a file and checks data, ID and tag of every response
`timescale 1ns/100ps
`default_nettype none

module floo_meta_tb import floo_meta_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 8;
  localparam int CYCLES_PER_PAT = 20;

  logic              clk_i;
  logic              rst_i;
  logic              req_valid_i;
  logic              req_ready_o;
  mem_op_e           req_op_i;
  logic [ID_W-1:0]   req_id_i;
  logic [ADDR_W-1:0] req_addr_i;
  logic [DATA_W-1:0] req_wdata_i;
  logic [META_W-1:0] req_meta_i;
  logic              rsp_valid_o;
  logic              rsp_ready_i;
  logic [ID_W-1:0]   rsp_id_o;
  logic [DATA_W-1:0] rsp_data_o;
  logic [META_W-1:0] rsp_meta_o;

  // One entry per pattern line
  logic [1:0]        pat_op [$];
  logic [ID_W-1:0]   pat_id [$];
  logic [ADDR_W-1:0] pat_addr [$];
  logic [DATA_W-1:0] pat_wdata [$];
  logic [META_W-1:0] pat_meta [$];
  logic [DATA_W-1:0] pat_rdata [$];
  // Indices of accepted requests still waiting for their response
  int                exp_q [$];
  integer            seed;
  int                rsp_cnt;
  int                data_errs;
  int                tag_errs;
  int                other_errs;

  floo_meta_top dut0 (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic load_patterns();
    int                fd;
    int                n;
    string             line;
    logic [1:0]        op;
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [META_W-1:0] meta;
    logic [DATA_W-1:0] rdata;
    fd = $fopen("verif/floo_meta_patterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the pattern file");
      other_errs++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h", op, id, addr, wdata, meta, rdata);
        if (n == 6) begin
          pat_op.push_back(op);
          pat_id.push_back(id);
          pat_addr.push_back(addr);
          pat_wdata.push_back(wdata);
          pat_meta.push_back(meta);
          pat_rdata.push_back(rdata);
        end
      end
    end
    $fclose(fd);
  endtask

  // Valid stays up with a stable payload until the request is taken
  task automatic drive_requests();
    for (int i = 0; i < pat_op.size(); i++) begin
      req_valid_i <= 1'b1;
      req_op_i    <= mem_op_e'(pat_op[i]);
      req_id_i    <= pat_id[i];
      req_addr_i  <= pat_addr[i];
      req_wdata_i <= pat_wdata[i];
      req_meta_i  <= pat_meta[i];
      @(posedge clk_i);
      while (!req_ready_o) begin
        @(posedge clk_i);
      end
      exp_q.push_back(i);
    end
    req_valid_i <= 1'b0;
  endtask

  task automatic collect_responses();
    int idx;
    while (rsp_cnt < pat_op.size()) begin
      @(posedge clk_i);
      if (rsp_valid_o && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("A response arrived while no request was outstanding");
          other_errs++;
        end else begin
          idx = exp_q.pop_front();
          assert (rsp_data_o == pat_rdata[idx]) else begin
            $display("ERR rsp_data_o pattern %0d exp %h got %h", idx, pat_rdata[idx], rsp_data_o);
            data_errs++;
          end
          assert (rsp_id_o == pat_id[idx]) else begin
            $display("ERR rsp_id_o pattern %0d exp %h got %h", idx, pat_id[idx], rsp_id_o);
            tag_errs++;
          end
          assert (rsp_meta_o == pat_meta[idx]) else begin
            $display("ERR rsp_meta_o pattern %0d exp %h got %h", idx, pat_meta[idx], rsp_meta_o);
            tag_errs++;
          end
        end
        rsp_cnt++;
      end
      // Back-pressure about one cycle in four
      rsp_ready_i <= ({$random(seed)} % 4) != 0;
    end
    rsp_ready_i <= 1'b1;
    // Nothing may follow the last response
    repeat (10) begin
      @(posedge clk_i);
      assert (!rsp_valid_o) else begin
        $display("ERR rsp_valid_o exp %h got %h after the last response", 1'b0, rsp_valid_o);
        other_errs++;
      end
    end
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_op_i    = OP_READ;
    req_id_i    = '0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_meta_i  = '0;
    rsp_ready_i = 1'b1;
    seed        = 71;
    rsp_cnt     = 0;
    data_errs   = 0;
    tag_errs    = 0;
    other_errs  = 0;
    load_patterns();
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    assert (!rsp_valid_o) else begin
      $display("ERR rsp_valid_o exp %h got %h after reset", 1'b0, rsp_valid_o);
      other_errs++;
    end
    assert (req_ready_o) else begin
      $display("ERR req_ready_o exp %h got %h after reset", 1'b1, req_ready_o);
      other_errs++;
    end
    if (pat_op.size() == 0) begin
      $display("No patterns were loaded");
      other_errs++;
    end else begin
      fork
        begin
          fork
            drive_requests();
            collect_responses();
          join
        end
        begin
          #(pat_op.size() * CYCLES_PER_PAT * CLK_PERIOD);
          $display("Timeout, only %0d of %0d responses arrived", rsp_cnt, pat_op.size());
          other_errs++;
        end
      join_any
      disable fork;
    end
    $display("Errors: data %0d, id/meta %0d, other %0d", data_errs, tag_errs, other_errs);
    if (data_errs + tag_errs + other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/floo_meta_patterns.txt */
# Columns in hex: op id addr wdata meta expected_rdata
# op 0 read, 1 write, 2 atomic add, 3 atomic swap
0 1 3 00000000 05 00000000
1 3 3 deadbeef 12 00000000
0 4 3 00000000 13 deadbeef
1 5 5 00000010 20 00000000
2 6 5 00000005 21 00000010
0 7 5 00000000 22 00000015
3 8 5 cafef00d 23 00000015
0 9 5 00000000 24 cafef00d
1 a 7 fffffffe 25 00000000
2 a 7 00000003 26 fffffffe
2 b 7 00000001 27 00000001
3 b 7 12345678 28 00000002
2 c 0 00000007 29 00000000
0 c 7 00000000 2a 12345678
1 1 1 11111111 30 00000000
1 1 2 22222222 31 00000000
1 1 4 44444444 32 00000000
1 1 6 66666666 33 00000000
0 1 1 00000000 34 11111111
0 1 2 00000000 35 22222222
0 1 4 00000000 36 44444444
0 1 6 00000000 37 66666666
3 f 2 aaaaaaaa 3f 22222222
0 e 2 00000000 00 aaaaaaaa
0 0 f 00000000 03 00000000
0 0 0 00000000 02 00000007

/* files.f */
design/floo_meta_pkg.sv
design/floo_meta_if.sv
design/floo_meta_fifo.sv
design/floo_atop_slots.sv
design/floo_meta_buffer.sv
design/floo_mem_target.sv
design/floo_meta_top.sv
verif/floo_meta_checker.sv
verif/floo_meta_tb.sv

/* Bender.yml */
package:
  name: floo_meta

sources:
  - design/floo_meta_pkg.sv
  - design/floo_meta_if.sv
  - design/floo_meta_fifo.sv
  - design/floo_atop_slots.sv
  - design/floo_meta_buffer.sv
  - design/floo_mem_target.sv
  - design/floo_meta_top.sv
  - target: test
    files:
      - verif/floo_meta_checker.sv
      - verif/floo_meta_tb.sv
